/* src.f */
verilog/rec_ctrl_pkg.sv
verilog/rec_audio_pkg.sv
verilog/key_debounce.sv
verilog/rec_ctrl_fsm.sv
verilog/sample_addr_timer.sv
verilog/aud_serial_port.sv
verilog/time_seven_seg.sv
verilog/rec_top.sv
verification/tb_rec_top.sv

/* verification/tb_rec_top.sv */
`timescale 1ns/100ps

module tb_rec_top;

	import rec_ctrl_pkg::*;
	import rec_audio_pkg::*;

	localparam int CLK_NS    = 20;
	localparam int FRAME_CLK = 256;
	localparam int N_STEPS   = 11;

	// one table row, key 3 means no key
	typedef struct packed {
		logic [1:0] key;
		logic [4:0] hold;
		logic [4:0] frames;
		rec_mode_t  mode;
		logic [7:0] words;
		logic [6:0] secs;
		logic [7:0] played;
	} step_t;

	logic        clk;
	logic        arst_n;
	logic [2:0]  key;
	logic        aud_bclk;
	logic        aud_lrck;
	logic        aud_adcdat;
	logic        aud_dacdat;
	mem_req_t    mem_req;
	sample_t     mem_rdata;
	rec_mode_t   mode;
	logic [6:0]  hex1;
	logic [6:0]  hex0;

	step_t       steps [N_STEPS];
	logic [15:0] mem [64];
	logic [15:0] rec_q [$];
	logic [15:0] played_q [$];
	logic [15:0] frame_sample;
	int          frame_no = 0;
	int          write_count = 0;
	logic        dac_loaded = 1'b0;
	int          pass_count = 0;
	int          err_count = 0;

	rec_top #(
		.DEBOUNCE_CYCLES(4),
		.SAMPLES_PER_SEC(4),
		.MEM_WORDS      (64)
	) dut0 (
		.i_clk        (clk),
		.i_arst_n     (arst_n),
		.i_key        (key),
		.i_aud_bclk   (aud_bclk),
		.i_aud_adclrck(aud_lrck),
		.i_aud_daclrck(aud_lrck),
		.i_aud_adcdat (aud_adcdat),
		.o_aud_dacdat (aud_dacdat),
		.o_mem_req    (mem_req),
		.i_mem_rdata  (mem_rdata),
		.o_mode       (mode),
		.o_hex1       (hex1),
		.o_hex0       (hex0)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("Error: time %0t signal %s got %0h expected %0h", $time, name, got, exp);
		end else begin
			pass_count++;
		end
	endtask

	// active-low g..a pattern back to a digit, 15 for anything else
	function automatic int seg_digit(input logic [6:0] seg);
		case (~seg)
			7'h3f: return 0;
			7'h06: return 1;
			7'h5b: return 2;
			7'h4f: return 3;
			7'h66: return 4;
			7'h6d: return 5;
			7'h7d: return 6;
			7'h07: return 7;
			7'h7f: return 8;
			7'h6f: return 9;
			default: return 15;
		endcase
	endfunction

	task automatic load_table();
		// key, hold cycles, frames, mode, memory words, seconds, words played
		steps[0]  = {2'd3, 5'd0,  5'd2, MODE_IDLE,       8'd0,  7'd0, 8'd0};
		// tap shorter than the debounce count
		steps[1]  = {2'd0, 5'd2,  5'd1, MODE_IDLE,       8'd0,  7'd0, 8'd0};
		steps[2]  = {2'd0, 5'd10, 5'd6, MODE_REC,        8'd6,  7'd1, 8'd0};
		steps[3]  = {2'd0, 5'd10, 5'd3, MODE_REC_PAUSE,  8'd6,  7'd1, 8'd0};
		steps[4]  = {2'd0, 5'd10, 5'd5, MODE_REC,        8'd11, 7'd2, 8'd0};
		steps[5]  = {2'd2, 5'd10, 5'd1, MODE_IDLE,       8'd11, 7'd2, 8'd0};
		steps[6]  = {2'd1, 5'd10, 5'd5, MODE_PLAY,       8'd11, 7'd1, 8'd5};
		steps[7]  = {2'd1, 5'd10, 5'd2, MODE_PLAY_PAUSE, 8'd11, 7'd1, 8'd5};
		// playback runs out after six frames
		steps[8]  = {2'd1, 5'd10, 5'd8, MODE_IDLE,       8'd11, 7'd2, 8'd11};
		steps[9]  = {2'd1, 5'd10, 5'd3, MODE_PLAY,       8'd11, 7'd0, 8'd3};
		steps[10] = {2'd2, 5'd10, 5'd2, MODE_IDLE,       8'd11, 7'd0, 8'd3};
	endtask

	task automatic press_key(input logic [1:0] k, input int hold);
		if (k != 2'd3) begin
			@(negedge clk);
			key[k] = 1'b0;
			repeat (hold) @(negedge clk);
			key[k] = 1'b1;
		end
	endtask

	task automatic wait_frame();
		int seen;
		seen = frame_no;
		@(posedge clk);
		while (frame_no == seen) @(posedge clk);
	endtask

	task automatic check_idle_outputs();
		compare("o_mode", mode, MODE_IDLE);
		compare("o_mem_req.we", mem_req.we, 1'b0);
		compare("o_mem_req.re", mem_req.re, 1'b0);
		compare("o_aud_dacdat", aud_dacdat, 1'b0);
		compare("o_hex1", seg_digit(hex1), 0);
		compare("o_hex0", seg_digit(hex0), 0);
	endtask

	// codec master, bit clock of 8 clk periods, 32 bits per frame
	initial begin
		logic [15:0] smp;
		logic [15:0] dac_word;
		int          rnd;
		rnd = $urandom(32'had59_2b3f);
		wait (arst_n === 1'b1);
		forever begin
			smp = 16'($urandom);
			for (int b = 0; b < 32; b++) begin
				@(negedge clk);
				aud_bclk = 1'b0;
				if (b == 0) begin
					aud_lrck     = 1'b0;
					frame_sample = smp;
					frame_no++;
				end else if (b == 16) begin
					aud_lrck = 1'b1;
				end
				// left word MSB first, one bit after the frame edge
				if (b >= 1 && b <= 16) aud_adcdat = smp[16-b];
				repeat (4) @(negedge clk);
				aud_bclk = 1'b1;
				if (b >= 1 && b <= 16) dac_word = {dac_word[14:0], aud_dacdat};
				if (b == 16 && dac_loaded) begin
					played_q.push_back(dac_word);
					dac_loaded = 1'b0;
				end
				repeat (3) @(negedge clk);
			end
		end
	end

	// sample memory, read data held from the re cycle on
	initial begin
		for (int a = 0; a < 64; a++) mem[a] = 16'(a * 16'h9e37) ^ 16'h5a5a;
	end

	always @(negedge clk) begin
		if (mem_req.we) begin
			mem[mem_req.addr[5:0]] = mem_req.wdata;
			write_count++;
		end
		if (mem_req.re) begin
			mem_rdata  = mem[mem_req.addr[5:0]];
			dac_loaded = 1'b1;
		end
	end

	initial begin
		longint limit_ns;
		int     total;
		#1;
		total = 0;
		for (int i = 0; i < N_STEPS; i++) total += steps[i].frames;
		// reset, setup frame and a few frames of margin
		limit_ns = longint'(total + 6) * FRAME_CLK * CLK_NS;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int          play_idx;
		int          mem_checked;
		int          step_err;
		logic [15:0] w;
		key        = 3'b111;
		aud_bclk   = 1'b1;
		aud_lrck   = 1'b1;
		aud_adcdat = 1'b0;
		mem_rdata  = '0;
		arst_n     = 1'b0;
		play_idx    = 0;
		mem_checked = 0;
		load_table();
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs();
		$display("reset check done: %0d mismatches", err_count);
		wait_frame();
		repeat (150) @(posedge clk);
		for (int i = 0; i < N_STEPS; i++) begin
			step_err = err_count;
			// play from idle starts over at address 0
			if (i > 0 && steps[i].key == 2'd1 && steps[i-1].mode == MODE_IDLE) play_idx = 0;
			press_key(steps[i].key, steps[i].hold);
			for (int f = 0; f < steps[i].frames; f++) begin
				wait_frame();
				if (steps[i].mode == MODE_REC) rec_q.push_back(frame_sample);
			end
			// past the write and the last dac bit of the frame
			repeat (150) @(posedge clk);
			@(negedge clk);
			compare("o_mode", mode, steps[i].mode);
			compare("write count", write_count, steps[i].words);
			compare("o_hex1", seg_digit(hex1), steps[i].secs / 10);
			compare("o_hex0", seg_digit(hex0), steps[i].secs % 10);
			while (mem_checked < rec_q.size()) begin
				compare($sformatf("mem[%0d]", mem_checked), mem[mem_checked], rec_q[mem_checked]);
				mem_checked++;
			end
			while (played_q.size() > 0) begin
				w = played_q.pop_front();
				if (play_idx < rec_q.size()) begin
					compare($sformatf("o_aud_dacdat word %0d", play_idx), w, rec_q[play_idx]);
				end else begin
					err_count++;
					$display("played word %0d has no recorded sample behind it", play_idx);
				end
				play_idx++;
			end
			compare("played words", play_idx, steps[i].played);
			$display("step %0d done: key %0d, %0d frames, %0d mismatches", i, steps[i].key,
				steps[i].frames, err_count - step_err);
		end
		$display("summary: %0d compares matched, %0d mismatched", pass_count, err_count);
		if (err_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* verilog/rec_top.sv */
`timescale 1ns/100ps

module rec_top #(
	parameter int DEBOUNCE_CYCLES = 50000,
	parameter int SAMPLES_PER_SEC = 32000,
	parameter int MEM_WORDS       = 1048575
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [2:0]              i_key,
	input  logic                    i_aud_bclk,
	input  logic                    i_aud_adclrck,
	input  logic                    i_aud_daclrck,
	input  logic                    i_aud_adcdat,
	output logic                    o_aud_dacdat,
	output rec_audio_pkg::mem_req_t o_mem_req,
	input  rec_audio_pkg::sample_t  i_mem_rdata,
	output rec_ctrl_pkg::rec_mode_t o_mode,
	output logic [6:0]              o_hex1,
	output logic [6:0]              o_hex0
);

	import rec_ctrl_pkg::*;
	import rec_audio_pkg::*;

	logic       key_rec;
	logic       key_play;
	logic       key_stop;
	key_pulse_t keys;
	mem_addr_t  addr;
	logic [6:0] seconds;
	logic       clear_addr;
	logic       rewind;
	logic       play_done;
	logic       mem_full;
	logic       sample_step;

	// record / pause
	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb0 (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_key   (i_key[0]),
		.o_press (key_rec)
	);

	// play / pause
	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb1 (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_key   (i_key[1]),
		.o_press (key_play)
	);

	// stop
	key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb2 (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_key   (i_key[2]),
		.o_press (key_stop)
	);

	assign keys = '{rec: key_rec, play: key_play, stop: key_stop};

	rec_ctrl_fsm fsm0 (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_keys      (keys),
		.i_play_done (play_done),
		.i_mem_full  (mem_full),
		.o_mode      (o_mode),
		.o_clear_addr(clear_addr),
		.o_rewind    (rewind)
	);

	sample_addr_timer #(
		.SAMPLES_PER_SEC(SAMPLES_PER_SEC),
		.MEM_WORDS      (MEM_WORDS)
	) timer0 (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_mode       (o_mode),
		.i_clear_addr (clear_addr),
		.i_rewind     (rewind),
		.i_sample_step(sample_step),
		.o_addr       (addr),
		.o_seconds    (seconds),
		.o_play_done  (play_done),
		.o_mem_full   (mem_full)
	);

	aud_serial_port aud0 (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_mode       (o_mode),
		.i_addr       (addr),
		.i_aud_bclk   (i_aud_bclk),
		.i_aud_adclrck(i_aud_adclrck),
		.i_aud_daclrck(i_aud_daclrck),
		.i_aud_adcdat (i_aud_adcdat),
		.i_mem_rdata  (i_mem_rdata),
		.o_aud_dacdat (o_aud_dacdat),
		.o_mem_req    (o_mem_req),
		.o_sample_step(sample_step)
	);

	time_seven_seg seven_dec0 (
		.i_seconds  (seconds),
		.o_seven_ten(o_hex1),
		.o_seven_one(o_hex0)
	);

endmodule

/* verilog/time_seven_seg.sv */
`timescale 1ns/100ps

module time_seven_seg (
	input  logic [6:0] i_seconds,
	output logic [6:0] o_seven_ten,
	output logic [6:0] o_seven_one
);

	logic [6:0] secs_mod;
	logic [3:0] digit_ten;
	logic [3:0] digit_one;

	// active low, segments g down to a
	function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
		logic [6:0] seg;
		case (digit)
			4'd0:    seg = 7'b1000000;
			4'd1:    seg = 7'b1111001;
			4'd2:    seg = 7'b0100100;
			4'd3:    seg = 7'b0110000;
			4'd4:    seg = 7'b0011001;
			4'd5:    seg = 7'b0010010;
			4'd6:    seg = 7'b0000010;
			4'd7:    seg = 7'b1111000;
			4'd8:    seg = 7'b0000000;
			4'd9:    seg = 7'b0010000;
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

	assign secs_mod  = i_seconds % 7'd100;
	assign digit_ten = 4'(secs_mod / 7'd10);
	assign digit_one = 4'(secs_mod % 7'd10);

	assign o_seven_ten = seg_pattern(digit_ten);
	assign o_seven_one = seg_pattern(digit_one);

endmodule

/* verilog/aud_serial_port.sv */
`timescale 1ns/100ps

module aud_serial_port (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  rec_ctrl_pkg::rec_mode_t  i_mode,
	input  rec_audio_pkg::mem_addr_t i_addr,
	input  logic                     i_aud_bclk,
	input  logic                     i_aud_adclrck,
	input  logic                     i_aud_daclrck,
	input  logic                     i_aud_adcdat,
	input  rec_audio_pkg::sample_t   i_mem_rdata,
	output logic                     o_aud_dacdat,
	output rec_audio_pkg::mem_req_t  o_mem_req,
	output logic                     o_sample_step
);

	import rec_ctrl_pkg::*;
	import rec_audio_pkg::*;

	localparam logic [4:0] RX_IDLE = 5'd17;

	// sync order: bclk, adc frame, dac frame, adc data
	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [2:0] sync_c;
	logic       bclk_rise;
	logic       bclk_fall;
	logic       adc_lr_fall;
	logic       dac_lr_fall;
	logic       rx_shift;
	logic       rx_done;
	logic       tx_shift;
	logic [4:0] rx_cnt;
	logic [4:0] tx_cnt;
	sample_t    rx_sr;
	sample_t    tx_sr;
	sample_t    wdata_q;
	logic       we_q;
	logic       re_q;
	logic       rd_pend;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_c <= '0;
		end else begin
			sync_a <= {i_aud_bclk, i_aud_adclrck, i_aud_daclrck, i_aud_adcdat};
			sync_b <= sync_a;
			sync_c <= sync_b[3:1];
		end
	end

	assign bclk_rise   = sync_b[3] & ~sync_c[2];
	assign bclk_fall   = ~sync_b[3] & sync_c[2];
	assign adc_lr_fall = ~sync_b[2] & sync_c[1];
	assign dac_lr_fall = ~sync_b[1] & sync_c[0];

	// first rise after the frame edge is the one-bit delay slot
	assign rx_shift = bclk_rise && !adc_lr_fall && (rx_cnt != RX_IDLE) && (rx_cnt != '0);
	assign rx_done  = rx_shift && (rx_cnt == 5'd16);
	assign tx_shift = bclk_fall && !rd_pend && (tx_cnt != '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rx_cnt       <= RX_IDLE;
			we_q         <= 1'b0;
			re_q         <= 1'b0;
			rd_pend      <= 1'b0;
			tx_cnt       <= '0;
			o_aud_dacdat <= 1'b0;
		end else begin
			if (adc_lr_fall) begin
				rx_cnt <= '0;
			end else if (bclk_rise && (rx_cnt != RX_IDLE)) begin
				rx_cnt <= rx_cnt + 5'd1;
			end
			we_q    <= rx_done && (i_mode == MODE_REC);
			re_q    <= dac_lr_fall && (i_mode == MODE_PLAY);
			rd_pend <= re_q;
			if (rd_pend) begin
				tx_cnt <= 5'd16;
			end else if (bclk_fall) begin
				// line rests low once the word is out
				o_aud_dacdat <= (tx_cnt != '0) ? tx_sr[15] : 1'b0;
				if (tx_cnt != '0) begin
					tx_cnt <= tx_cnt - 5'd1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rx_shift) begin
			rx_sr <= {rx_sr[14:0], sync_b[0]};
		end
		if (rx_done) begin
			wdata_q <= {rx_sr[14:0], sync_b[0]};
		end
		// read data is valid the cycle after re
		if (rd_pend) begin
			tx_sr <= i_mem_rdata;
		end else if (tx_shift) begin
			tx_sr <= {tx_sr[14:0], 1'b0};
		end
	end

	assign o_mem_req = '{addr: i_addr, we: we_q, re: re_q, wdata: wdata_q};

	assign o_sample_step = we_q | rd_pend;

	a_we_only_record: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_mem_req.we |-> ($past(i_mode) == MODE_REC))
		else $error("memory write outside record mode");

	a_we_re_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_mem_req.we && o_mem_req.re))
		else $error("write and read strobes together");

endmodule

/* verilog/sample_addr_timer.sv */
`timescale 1ns/100ps

module sample_addr_timer #(
	parameter int SAMPLES_PER_SEC = 32000,
	parameter int MEM_WORDS       = 1048575
) (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  rec_ctrl_pkg::rec_mode_t  i_mode,
	input  logic                     i_clear_addr,
	input  logic                     i_rewind,
	input  logic                     i_sample_step,
	output rec_audio_pkg::mem_addr_t o_addr,
	output logic [6:0]               o_seconds,
	output logic                     o_play_done,
	output logic                     o_mem_full
);

	import rec_ctrl_pkg::*;
	import rec_audio_pkg::*;

	localparam int        SUB_W      = (SAMPLES_PER_SEC > 1) ? $clog2(SAMPLES_PER_SEC) : 1;
	localparam mem_addr_t ADDR_LIMIT = mem_addr_t'(MEM_WORDS);

	mem_addr_t        rec_len;
	logic [SUB_W-1:0] sub_cnt;
	logic             advance;
	logic             sec_tick;

	assign o_mem_full = (o_addr >= ADDR_LIMIT);

	// steps only move the address inside the valid range of the mode
	assign advance = i_sample_step &&
		(((i_mode == MODE_REC) && !o_mem_full) ||
		((i_mode == MODE_PLAY) && (o_addr < rec_len)));

	assign sec_tick = advance && (sub_cnt == SUB_W'(SAMPLES_PER_SEC - 1));

	// last stored word has just been fetched
	assign o_play_done = i_sample_step && (i_mode == MODE_PLAY) &&
		((o_addr + mem_addr_t'(1)) >= rec_len);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_addr    <= '0;
			rec_len   <= '0;
			sub_cnt   <= '0;
			o_seconds <= '0;
		end else if (i_clear_addr) begin
			o_addr    <= '0;
			rec_len   <= '0;
			sub_cnt   <= '0;
			o_seconds <= '0;
		end else if (i_rewind) begin
			o_addr    <= '0;
			sub_cnt   <= '0;
			o_seconds <= '0;
		end else if (advance) begin
			o_addr <= o_addr + mem_addr_t'(1);
			if (i_mode == MODE_REC) begin
				rec_len <= o_addr + mem_addr_t'(1);
			end
			sub_cnt <= sec_tick ? '0 : sub_cnt + 1'b1;
			// display tops out at 99
			if (sec_tick && (o_seconds != 7'd99)) begin
				o_seconds <= o_seconds + 7'd1;
			end
		end
	end

	a_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_addr <= ADDR_LIMIT)
		else $error("address ran past the memory size");

	a_play_in_recording: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_mode == MODE_PLAY) |-> (o_addr <= rec_len))
		else $error("playback address beyond recorded length");

endmodule

/* verilog/rec_ctrl_fsm.sv */
`timescale 1ns/100ps

module rec_ctrl_fsm (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  rec_ctrl_pkg::key_pulse_t i_keys,
	input  logic                     i_play_done,
	input  logic                     i_mem_full,
	output rec_ctrl_pkg::rec_mode_t  o_mode,
	output logic                     o_clear_addr,
	output logic                     o_rewind
);

	import rec_ctrl_pkg::*;

	rec_mode_t mode_next;

	always_comb begin
		mode_next = o_mode;
		if (i_keys.stop) begin
			mode_next = MODE_IDLE;
		end else begin
			case (o_mode)
				MODE_IDLE: begin
					if (i_keys.rec) begin
						mode_next = MODE_REC;
					end else if (i_keys.play) begin
						mode_next = MODE_PLAY;
					end
				end
				MODE_REC: begin
					// a full memory pauses just like the key does
					if (i_keys.rec || i_mem_full) begin
						mode_next = MODE_REC_PAUSE;
					end
				end
				MODE_REC_PAUSE: begin
					if (i_keys.rec && !i_mem_full) begin
						mode_next = MODE_REC;
					end
				end
				MODE_PLAY: begin
					if (i_keys.play) begin
						mode_next = MODE_PLAY_PAUSE;
					end else if (i_play_done) begin
						mode_next = MODE_IDLE;
					end
				end
				MODE_PLAY_PAUSE: begin
					if (i_keys.play) begin
						mode_next = MODE_PLAY;
					end
				end
				default: mode_next = MODE_IDLE;
			endcase
		end
	end

	// counter is cleared on the same edge the new mode starts
	assign o_clear_addr = (o_mode == MODE_IDLE) && (mode_next == MODE_REC);
	assign o_rewind     = (o_mode == MODE_IDLE) && (mode_next == MODE_PLAY);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mode <= MODE_IDLE;
		end else begin
			o_mode <= mode_next;
		end
	end

	a_clear_rewind_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_clear_addr && o_rewind))
		else $error("clear and rewind raised together");

	// a key pulse lasts one cycle, so it moves the mode only once
	a_key_pulse_once: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_keys & $past(i_keys)) == '0)
		else $error("key pulse held high on consecutive cycles");

endmodule

/* verilog/key_debounce.sv */
`timescale 1ns/100ps

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 50000
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_key,
	output logic o_press
);

	localparam logic [15:0] LAST_CNT = 16'(DEBOUNCE_CYCLES - 1);

	logic [1:0]  key_sync;
	logic [15:0] low_cnt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			key_sync <= 2'b11;
			low_cnt  <= '0;
			o_press  <= 1'b0;
		end else begin
			key_sync <= {key_sync[0], i_key};
			o_press  <= 1'b0;
			if (key_sync[1]) begin
				// key released, ready for the next press
				low_cnt <= '0;
			end else if (low_cnt <= LAST_CNT) begin
				low_cnt <= low_cnt + 16'd1;
				// fires once, then the count parks one past the limit
				o_press <= (low_cnt == LAST_CNT);
			end
		end
	end

endmodule

/* verilog/rec_audio_pkg.sv */
package rec_audio_pkg;

	// one left-channel audio sample
	typedef logic signed [15:0] sample_t;

	// word address into the external sample memory
	typedef logic [19:0] mem_addr_t;

	// one memory access per cycle, we and re exclusive
	typedef struct packed {
		mem_addr_t addr;
		logic      we;
		logic      re;
		sample_t   wdata;
	} mem_req_t;

endpackage

/* verilog/rec_ctrl_pkg.sv */
package rec_ctrl_pkg;

	// recorder operating modes
	typedef enum logic [2:0] {
		MODE_IDLE       = 3'd0,
		MODE_REC        = 3'd1,
		MODE_REC_PAUSE  = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} rec_mode_t;

	// one-cycle key pulses after debouncing
	typedef struct packed {
		logic rec;
		logic play;
		logic stop;
	} key_pulse_t;

endpackage
